/* sim.f */
+incdir+hw
+incdir+verif
hw/mpeg_sys_pkg.sv
hw/mpeg_sys_ifs.sv
hw/start_code_detect.sv
hw/field_capture.sv
hw/pack_header_parser.sv
hw/system_header_parser.sv
hw/stream_table.sv
hw/mpeg_sys_demux_top.sv
verif/tb_mpeg_sys.sv

/* verif/tb_stream_tasks.svh */
// byte-level stimulus, header builders and the stream table model for the demux testbench

`ifndef TB_STREAM_TASKS_SVH
`define TB_STREAM_TASKS_SVH

// ************************************************************
// byte driving
// ************************************************************

// one byte, after a random number of idle cycles
task put_byte(input logic [7:0] b);
	while ($urandom % 4 == 0) begin
		@(posedge clk);
		byte_en <= 1'b0;
	end
	@(posedge clk);
	byte_en <= 1'b1;
	byte_data <= b;
	bytes_sent++;
endtask

task go_idle(input int cycles);
	repeat (cycles) begin
		@(posedge clk);
		byte_en <= 1'b0;
	end
endtask

task put_prefix(input logic [7:0] code);
	put_byte(8'h00);
	put_byte(8'h00);
	put_byte(8'h01);
	put_byte(code);
endtask

// never 00 or 01, so filler can not fake a prefix
task send_filler(input int n);
	repeat (n) put_byte(8'($urandom % 254 + 2));
endtask

// ************************************************************
// expected stream table
// ************************************************************

task model_write(input logic [7:0] id, input logic [13:0] bs);
	bit found;
	found = 0;
	for (int i = 0; i < tbl_n; i++) begin
		if (tbl_id[i] == id) begin
			tbl_bs[i] = bs;
			found = 1;
		end
	end
	// a full table drops new ids
	if (!found && tbl_n < `STREAM_SLOTS) begin
		tbl_id[tbl_n] = id;
		tbl_bs[tbl_n] = bs;
		tbl_n++;
	end
endtask

function automatic bit model_lookup(input logic [7:0] id, output logic [13:0] bs);
	bit hit;
	hit = 0;
	bs = '0;
	for (int i = 0; i < tbl_n; i++) begin
		if (tbl_id[i] == id) begin
			hit = 1;
			bs = tbl_bs[i];
		end
	end
	return hit;
endfunction

// distinct ids with bit 7 set and random buffer sizes
task pick_entries(input int n);
	ent_n = n;
	for (int i = 0; i < n; i++) begin
		ent_id[i] = {1'b1, 7'(i * 9 + $urandom % 9)};
		ent_bs[i] = 14'($urandom);
	end
endtask

// ************************************************************
// header builders
// ************************************************************

// bad < 0 gives a clean header, 0..4 flips a marker, 5 breaks the 0010 nibble
task send_pack(input int bad);
	logic [32:0] s;
	logic [21:0] r;
	logic [7:0] body [8];
	s = {1'($urandom), 32'($urandom)};
	r = 22'($urandom);
	if (bad >= 0) begin
		// keep every body byte non-zero once a marker is cleared
		s = s | 33'h0_0000_8001;
		r = r | 22'h00_8001;
	end
	body[0] = {4'b0010, s[32:30], 1'b1};
	body[1] = s[29:22];
	body[2] = {s[21:15], 1'b1};
	body[3] = s[14:7];
	body[4] = {s[6:0], 1'b1};
	body[5] = {1'b1, r[21:15]};
	body[6] = r[14:7];
	body[7] = {r[6:0], 1'b1};
	case (bad)
		0: body[0][0] = 1'b0;
		1: body[2][0] = 1'b0;
		2: body[4][0] = 1'b0;
		3: body[5][7] = 1'b0;
		4: body[7][0] = 1'b0;
		5: body[0][7:4] = 4'b0011;
		default: ;
	endcase
	if (bad < 0) begin
		exp_scr = s;
		exp_mux = r;
		exp_pack_valid++;
	end else begin
		exp_pack_err++;
	end
	put_prefix(CODE_PACK);
	for (int i = 0; i < 8; i++) put_byte(body[i]);
endtask

// fault 0 is clean, 1 clears bit 7 of entry arg, 2 adds arg stray bytes
task send_system(input int fault, input int arg);
	logic [15:0] len;
	logic [21:0] rate;
	logic [5:0] aud;
	logic [4:0] vid;
	logic [3:0] fl;
	int extra;
	int n_sent;
	extra = (fault == 2) ? arg : 0;
	len = 16'(6 + 3 * ent_n + extra);
	rate = 22'($urandom);
	aud = 6'($urandom);
	vid = 5'($urandom);
	// fixed, csps, audio lock, video lock from the top
	fl = 4'($urandom);
	exp_len = len;
	exp_rate = rate;
	exp_audio = aud;
	exp_video = vid;
	exp_flags = fl;
	// every system header starts from an empty table
	tbl_n = 0;
	if (fault == 0) exp_sys_valid++;
	else exp_sys_err++;
	put_prefix(CODE_SYSTEM);
	put_byte(len[15:8]);
	put_byte(len[7:0]);
	put_byte({1'b1, rate[21:15]});
	put_byte(rate[14:7]);
	put_byte({rate[6:0], 1'b1});
	put_byte({aud, fl[3], fl[2]});
	put_byte({fl[1], fl[0], 1'b1, vid});
	put_byte(8'hff);
	// the header stops at a bad id
	n_sent = (fault == 1) ? arg + 1 : ent_n;
	for (int i = 0; i < n_sent; i++) begin
		if (fault == 1 && i == arg) begin
			put_byte({1'b0, ent_id[i][6:0]});
		end else begin
			put_byte(ent_id[i]);
			put_byte({2'b11, ent_bs[i][13:8]});
			put_byte(ent_bs[i][7:0]);
			model_write(ent_id[i], ent_bs[i]);
		end
	end
	// start of an entry that the length cuts off
	if (fault == 2) begin
		put_byte(8'he5);
		if (arg == 2) put_byte(8'hc0);
	end
endtask

`endif

/* verif/tb_mpeg_sys.sv */
// testbench for the MPEG-1 system stream front end, pack and system headers and table lookups
`default_nettype none
`include "mpeg_sys_defs.svh"

module tb_mpeg_sys import mpeg_sys_pkg::*; ();

	logic clk;
	logic rst_n;
	logic byte_en;
	logic [7:0] byte_data;
	logic [7:0] query_id;
	logic pack_valid;
	logic pack_err;
	logic [32:0] scr;
	logic [21:0] mux_rate;
	logic sys_valid;
	logic sys_err;
	logic [15:0] header_len;
	logic [21:0] rate_bound;
	logic [5:0] audio_bound;
	logic [4:0] video_bound;
	sys_flags_t sys_flags;
	logic [3:0] stream_count;
	logic query_hit;
	logic [13:0] query_bufsize;

	// scoreboard, written by the header builders
	logic [32:0] exp_scr = '0;
	logic [21:0] exp_mux = '0;
	logic [15:0] exp_len = '0;
	logic [21:0] exp_rate = '0;
	logic [5:0] exp_audio = '0;
	logic [4:0] exp_video = '0;
	sys_flags_t exp_flags = '0;
	int exp_pack_valid = 0;
	int exp_pack_err = 0;
	int exp_sys_valid = 0;
	int exp_sys_err = 0;
	// pulses seen on the outputs
	int n_pack_valid = 0;
	int n_pack_err = 0;
	int n_sys_valid = 0;
	int n_sys_err = 0;
	// entries sent in the last system header, and the expected table
	logic [7:0] ent_id [16];
	logic [13:0] ent_bs [16];
	int ent_n = 0;
	logic [7:0] tbl_id [`STREAM_SLOTS];
	logic [13:0] tbl_bs [`STREAM_SLOTS];
	int tbl_n = 0;
	int bytes_sent = 0;
	int cycles = 0;

	mpeg_sys_demux_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.byte_en(byte_en),
		.byte_data(byte_data),
		.query_id(query_id),
		.pack_valid(pack_valid),
		.pack_err(pack_err),
		.scr(scr),
		.mux_rate(mux_rate),
		.sys_valid(sys_valid),
		.sys_err(sys_err),
		.header_len(header_len),
		.rate_bound(rate_bound),
		.audio_bound(audio_bound),
		.video_bound(video_bound),
		.sys_flags(sys_flags),
		.stream_count(stream_count),
		.query_hit(query_hit),
		.query_bufsize(query_bufsize)
	);

	task abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task report_mismatch(input string what);
		abort_run($sformatf("[ERROR] %0t %s", $time, what));
	endtask

	`include "tb_stream_tasks.svh"

	// ************************************************************
	// clock, pulse counters and watchdog
	// ************************************************************

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			n_pack_valid += int'(pack_valid);
			n_pack_err += int'(pack_err);
			n_sys_valid += int'(sys_valid);
			n_sys_err += int'(sys_err);
		end
	end

	// budget grows with the bytes driven so far
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > 4 * bytes_sent + 200)
			abort_run($sformatf("timeout: no finish after %0d cycles for %0d bytes",
				cycles, bytes_sent));
	end

	// ************************************************************
	// field checks on every end-of-header pulse
	// ************************************************************

	pack_fields: assert property (
		@(posedge clk) disable iff (!rst_n)
		(pack_valid || pack_err) |-> (scr == exp_scr && mux_rate == exp_mux)
	) else report_mismatch($sformatf("pack fields scr %09h mux %06h, expected %09h %06h",
		$sampled(scr), $sampled(mux_rate), exp_scr, exp_mux));

	sys_fields: assert property (
		@(posedge clk) disable iff (!rst_n)
		(sys_valid || sys_err) |-> (header_len == exp_len && rate_bound == exp_rate
			&& audio_bound == exp_audio && video_bound == exp_video && sys_flags == exp_flags)
	) else report_mismatch($sformatf("system fields len %04h rate %06h, expected %04h %06h",
		$sampled(header_len), $sampled(rate_bound), exp_len, exp_rate));

	// table settles one clock after the last write
	sys_count: assert property (
		@(posedge clk) disable iff (!rst_n)
		(sys_valid || sys_err) |=> (stream_count == 4'(tbl_n))
	) else report_mismatch($sformatf("stream_count %0d, expected %0d",
		$sampled(stream_count), tbl_n));

	// ************************************************************
	// procedural checks
	// ************************************************************

	task await_pulse();
		int waited;
		logic got;
		waited = 0;
		got = 1'b0;
		@(posedge clk);
		byte_en <= 1'b0;
		while (!got && waited < 32) begin
			@(negedge clk);
			got = pack_valid || pack_err || sys_valid || sys_err;
			waited++;
		end
		if (!got) abort_run("no end-of-header pulse came within 32 cycles of the last byte");
		go_idle(2);
	endtask

	task check_counts();
		@(negedge clk);
		assert (n_pack_valid == exp_pack_valid && n_pack_err == exp_pack_err
			&& n_sys_valid == exp_sys_valid && n_sys_err == exp_sys_err
			&& stream_count == 4'(tbl_n))
		else report_mismatch($sformatf("pulses %0d/%0d/%0d/%0d count %0d, expected %0d/%0d/%0d/%0d %0d",
			n_pack_valid, n_pack_err, n_sys_valid, n_sys_err, stream_count,
			exp_pack_valid, exp_pack_err, exp_sys_valid, exp_sys_err, tbl_n));
	endtask

	// every id of the last header, then one that is never used
	task check_lookups();
		logic [13:0] bs;
		logic hit;
		for (int i = 0; i <= ent_n; i++) begin
			@(posedge clk);
			query_id <= (i < ent_n) ? ent_id[i] : 8'h00;
			@(negedge clk);
			hit = model_lookup(query_id, bs);
			assert (query_hit == hit && (!hit || query_bufsize == bs))
			else report_mismatch($sformatf("lookup %02h gave hit %0b size %04h, expected %0b %04h",
				query_id, query_hit, query_bufsize, hit, bs));
		end
	endtask

	task check_reset_state();
		@(negedge clk);
		assert (!pack_valid && !pack_err && !sys_valid && !sys_err && scr == '0
			&& mux_rate == '0 && header_len == '0 && rate_bound == '0 && audio_bound == '0
			&& video_bound == '0 && sys_flags == '0 && stream_count == '0 && !query_hit)
		else report_mismatch("outputs not cleared after reset");
	endtask

	// ************************************************************
	// test sequence
	// ************************************************************

	initial begin
		void'($urandom(32'hd34f));
		rst_n = 1'b0;
		byte_en = 1'b0;
		byte_data = 8'h00;
		query_id = 8'h00;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		check_reset_state();
		check_lookups();

		// clean pack headers, then one bad marker or nibble each
		repeat (4) begin
			send_pack(-1);
			await_pulse();
			check_counts();
		end
		repeat (4) begin
			send_pack(int'($urandom % 6));
			await_pulse();
			check_counts();
		end

		// one to eight distinct entries
		for (int n = 1; n <= 8; n++) begin
			pick_entries(n);
			send_system(0, 0);
			await_pulse();
			check_counts();
			check_lookups();
		end

		// repeated id keeps the last size
		pick_entries(5);
		ent_id[3] = ent_id[1];
		send_system(0, 0);
		await_pulse();
		check_counts();
		check_lookups();

		// ten entries overflow the table
		pick_entries(10);
		send_system(0, 0);
		await_pulse();
		check_counts();
		check_lookups();

		// malformed system headers
		pick_entries(6);
		send_system(1, int'($urandom % 6));
		await_pulse();
		check_counts();
		check_lookups();
		for (int r = 1; r <= 2; r++) begin
			pick_entries(4);
			send_system(2, r);
			await_pulse();
			check_counts();
			check_lookups();
		end

		// filler, foreign codes and a cut pack header stay silent
		send_filler(24);
		put_prefix(8'he0);
		send_filler(6);
		put_prefix(8'hc0);
		put_prefix(8'hbc);
		send_filler(5);
		put_prefix(CODE_PACK);
		send_filler(1 + int'($urandom % 4));
		go_idle(4);
		check_counts();
		send_pack(-1);
		await_pulse();
		check_counts();
		send_filler(12);
		pick_entries(3);
		send_system(0, 0);
		await_pulse();
		check_counts();
		check_lookups();

		go_idle(5);
		check_counts();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/mpeg_sys_demux_top.sv */
// MPEG-1 system stream front end, start codes, pack and system headers
`default_nettype none

module mpeg_sys_demux_top import mpeg_sys_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic byte_en,
	input logic [7:0] byte_data,
	input logic [7:0] query_id,
	output logic pack_valid,
	output logic pack_err,
	output logic [32:0] scr,
	output logic [21:0] mux_rate,
	output logic sys_valid,
	output logic sys_err,
	output logic [15:0] header_len,
	output logic [21:0] rate_bound,
	output logic [5:0] audio_bound,
	output logic [4:0] video_bound,
	output sys_flags_t sys_flags,
	output logic [3:0] stream_count,
	output logic query_hit,
	output logic [13:0] query_bufsize
);

	byte_stream_if bs_if ();
	stream_entry_if tbl_if ();

	start_code_detect scd_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(byte_data),
		.in_en(byte_en),
		.bs(bs_if.src)
	);

	pack_header_parser pack_i (
		.clk(clk),
		.rst_n(rst_n),
		.bs(bs_if.dst),
		.pack_valid(pack_valid),
		.pack_err(pack_err),
		.scr(scr),
		.mux_rate(mux_rate)
	);

	system_header_parser sys_i (
		.clk(clk),
		.rst_n(rst_n),
		.bs(bs_if.dst),
		.tbl(tbl_if.wr_port),
		.sys_valid(sys_valid),
		.sys_err(sys_err),
		.header_len(header_len),
		.rate_bound(rate_bound),
		.audio_bound(audio_bound),
		.video_bound(video_bound),
		.sys_flags(sys_flags)
	);

	stream_table table_i (
		.clk(clk),
		.rst_n(rst_n),
		.tbl(tbl_if.table_port),
		.query_id(query_id),
		.query_hit(query_hit),
		.query_bufsize(query_bufsize)
	);

	assign stream_count = tbl_if.count;

endmodule

`default_nettype wire

/* hw/stream_table.sv */
// stream id table with update-or-append writes and an associative lookup
`default_nettype none
`include "mpeg_sys_defs.svh"

module stream_table import mpeg_sys_pkg::*; (
	input logic clk,
	input logic rst_n,
	stream_entry_if.table_port tbl,
	input logic [7:0] query_id,
	output logic query_hit,
	output logic [13:0] query_bufsize
);

	localparam int slots = `STREAM_SLOTS;
	localparam int iw = $clog2(slots);

	stream_entry_t slot [slots];
	// slots fill from 0 upwards, so the count marks the occupied ones
	logic [3:0] count_q;
	logic full;
	// id of the write already present, and where
	logic wr_hit;
	logic [iw-1:0] wr_idx;

	assign full = (count_q == 4'(slots));

	always_comb begin
		wr_hit = 1'b0;
		wr_idx = '0;
		for (int i = 0; i < slots; i++) begin
			if ((i < int'(count_q)) && (slot[i].stream_id == tbl.entry.stream_id)) begin
				wr_hit = 1'b1;
				wr_idx = iw'(i);
			end
		end
	end

	// occupancy
	always_ff @(posedge clk) begin
		if (!rst_n) count_q <= '0;
		else if (tbl.clear) count_q <= '0;
		else if (tbl.wr && !wr_hit && !full) count_q <= count_q + 4'd1;
	end

	// contents, a write past a full table is dropped
	always_ff @(posedge clk) begin
		if (tbl.wr) begin
			if (wr_hit) slot[wr_idx] <= tbl.entry;
			else if (!full) slot[count_q[iw-1:0]] <= tbl.entry;
		end
	end

	assign tbl.count = count_q;

	// lookup, scale bit on top of the 13-bit size
	always_comb begin
		query_hit = 1'b0;
		query_bufsize = '0;
		for (int i = 0; i < slots; i++) begin
			if ((i < int'(count_q)) && (slot[i].stream_id == query_id)) begin
				query_hit = 1'b1;
				query_bufsize = {slot[i].bufsize_scale, slot[i].bufsize};
			end
		end
	end

	count_bound: assert property (
		@(posedge clk) disable iff (!rst_n)
		tbl.count <= 4'(slots)
	);

endmodule

`default_nettype wire

/* hw/system_header_parser.sv */
// system header parser, decodes the fixed part and writes the stream entries
`default_nettype none
`include "mpeg_sys_defs.svh"

module system_header_parser import mpeg_sys_pkg::*; (
	input logic clk,
	input logic rst_n,
	byte_stream_if.dst bs,
	stream_entry_if.wr_port tbl,
	output logic sys_valid,
	output logic sys_err,
	output logic [15:0] header_len,
	output logic [21:0] rate_bound,
	output logic [5:0] audio_bound,
	output logic [4:0] video_bound,
	output sys_flags_t sys_flags
);

	// bytes of the fixed part counted by header_len
	localparam logic [15:0] fix_after_len = 16'(`SYS_FIXED_BYTES - 2);
	localparam logic [1:0] last_idx = 2'(`ENTRY_BYTES - 1);

	sys_fixed_t fix;
	logic arm;
	logic cap_busy;
	logic cap_done;
	// inside a system header, dropped by any other code
	logic live;
	// fixed part latched and remaining count running
	logic loaded;
	logic [15:0] rem;
	logic [15:0] rem_cur;
	logic [15:0] rem_next;
	// byte position inside the current entry
	logic [1:0] idx;
	logic [7:0] ent_id;
	logic [7:0] ent_mid;
	stream_entry_t entry_q;
	logic fresh;
	logic short_hdr;
	logic fix_end;
	logic ent_active;
	logic ent_step;
	logic bad_id;
	logic ent_last;
	logic hdr_last;
	logic [21:0] rate_new;
	sys_flags_t flags_new;
	logic [15:0] len_q;
	logic [21:0] rate_q;
	logic [5:0] audio_q;
	logic [4:0] video_q;
	sys_flags_t flags_q;
	logic clear_q;
	logic wr_q;
	logic valid_q;
	logic err_q;

	assign arm = bs.code_hit && (bs.code == CODE_SYSTEM);

	field_capture #(
		.payload_t(sys_fixed_t),
		.n_bytes(`SYS_FIXED_BYTES)
	) fixed_cap_i (
		.clk(clk),
		.rst_n(rst_n),
		.arm(arm),
		.en(bs.en),
		.data(bs.data),
		.busy(cap_busy),
		.done(cap_done),
		.payload(fix)
	);

	// ************************************************************
	// fixed part
	// ************************************************************

	assign fresh = live && !cap_busy && !loaded;
	// no room left for entries, header ends with the fixed part
	assign short_hdr = fix.length <= fix_after_len;
	assign fix_end = live && cap_done && short_hdr;

	assign rate_new = fix.rate_field[22:1];
	assign flags_new = '{
		fixed_flag: fix.audio_byte[1],
		csps_flag: fix.audio_byte[0],
		audio_lock: fix.video_byte[7],
		video_lock: fix.video_byte[6]
	};

	// fields follow the capture until latched on the next byte
	assign header_len = fresh ? fix.length : len_q;
	assign rate_bound = fresh ? rate_new : rate_q;
	assign audio_bound = fresh ? fix.audio_byte[7:2] : audio_q;
	assign video_bound = fresh ? fix.video_byte[4:0] : video_q;
	assign sys_flags = fresh ? flags_new : flags_q;

	// ************************************************************
	// entry collection
	// ************************************************************

	assign ent_active = live && !cap_busy && (loaded || !short_hdr);
	assign ent_step = bs.en && !bs.code_hit && ent_active;
	// first entry byte uses the count straight from the length field
	assign rem_cur = loaded ? rem : fix.length - fix_after_len;
	assign rem_next = rem_cur - 16'd1;
	// stream id bytes always have bit 7 set
	assign bad_id = (idx == 2'd0) && !bs.data[7];
	assign ent_last = (idx == last_idx);
	assign hdr_last = (rem_next == 16'd0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			live <= 1'b0;
			loaded <= 1'b0;
			rem <= '0;
			idx <= '0;
			len_q <= '0;
			rate_q <= '0;
			audio_q <= '0;
			video_q <= '0;
			flags_q <= '0;
		end else if (bs.en) begin
			if (bs.code_hit) begin
				// BB restarts, anything else aborts
				live <= arm;
				loaded <= 1'b0;
				idx <= '0;
			end else begin
				if (fresh) begin
					loaded <= 1'b1;
					len_q <= fix.length;
					rate_q <= rate_new;
					audio_q <= fix.audio_byte[7:2];
					video_q <= fix.video_byte[4:0];
					flags_q <= flags_new;
					if (short_hdr) live <= 1'b0;
				end
				if (ent_active) begin
					rem <= rem_next;
					idx <= ent_last ? 2'd0 : idx + 2'd1;
					if (bad_id || hdr_last) live <= 1'b0;
				end
			end
		end
	end

	// entry bytes, assembled on the third
	always_ff @(posedge clk) begin
		if (ent_step) begin
			case (idx)
				2'd0: ent_id <= bs.data;
				2'd1: ent_mid <= bs.data;
				default: entry_q <= '{
					stream_id: ent_id,
					bufsize_scale: ent_mid[5],
					bufsize: {ent_mid[4:0], bs.data}
				};
			endcase
		end
	end

	// single-clock pulses
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			clear_q <= 1'b0;
			wr_q <= 1'b0;
			valid_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			clear_q <= arm;
			wr_q <= ent_step && ent_last;
			valid_q <= ent_step && ent_last && hdr_last;
			// length ran out part way through an entry
			err_q <= ent_step && (bad_id || (hdr_last && !ent_last));
		end
	end

	assign tbl.clear = clear_q;
	assign tbl.wr = wr_q;
	assign tbl.entry = entry_q;

	// length 6 ends right at the fixed part, shorter is malformed
	assign sys_valid = valid_q || (fix_end && (fix.length == fix_after_len));
	assign sys_err = err_q || (fix_end && (fix.length != fix_after_len));

	sys_end_exclusive: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(sys_valid && sys_err)
	);

endmodule

`default_nettype wire

/* hw/pack_header_parser.sv */
// pack header parser, takes SCR and mux rate from the body after a BA code
`default_nettype none
`include "mpeg_sys_defs.svh"

module pack_header_parser import mpeg_sys_pkg::*; (
	input logic clk,
	input logic rst_n,
	byte_stream_if.dst bs,
	output logic pack_valid,
	output logic pack_err,
	output logic [32:0] scr,
	output logic [21:0] mux_rate
);

	pack_hdr_t hdr;
	logic arm;
	logic cap_busy;
	logic cap_done;
	// inside a pack header, dropped by any other code
	logic live;
	// body complete and not yet latched
	logic fresh;
	logic fmt_ok;
	logic [32:0] scr_new;
	logic [21:0] rate_new;
	logic [32:0] scr_q;
	logic [21:0] rate_q;

	assign arm = bs.code_hit && (bs.code == CODE_PACK);

	field_capture #(
		.payload_t(pack_hdr_t),
		.n_bytes(`PACK_BODY_BYTES)
	) body_cap_i (
		.clk(clk),
		.rst_n(rst_n),
		.arm(arm),
		.en(bs.en),
		.data(bs.data),
		.busy(cap_busy),
		.done(cap_done),
		.payload(hdr)
	);

	// ************************************************************
	// MPEG-1 pack layout
	// ************************************************************

	// 0010 prefix and the five marker bits
	assign fmt_ok = (hdr[0][7:4] == 4'b0010) && hdr[0][0] && hdr[2][0] && hdr[4][0]
		&& hdr[5][7] && hdr[7][0];
	// SCR split 3 + 15 + 15 over bytes 0..4
	assign scr_new = {hdr[0][3:1], hdr[1], hdr[2][7:1], hdr[3], hdr[4][7:1]};
	// mux_rate between the two markers
	assign rate_new = {hdr[5][6:0], hdr[6], hdr[7][7:1]};

	assign fresh = live && !cap_busy;
	assign pack_valid = live && cap_done && fmt_ok;
	assign pack_err = live && cap_done && !fmt_ok;

	// new fields show while fresh, then come from the held copy
	assign scr = (fresh && fmt_ok) ? scr_new : scr_q;
	assign mux_rate = (fresh && fmt_ok) ? rate_new : rate_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			live <= 1'b0;
			scr_q <= '0;
			rate_q <= '0;
		end else if (bs.en) begin
			// a bad header leaves the previous fields in place
			if (fresh && fmt_ok) begin
				scr_q <= scr_new;
				rate_q <= rate_new;
			end
			if (bs.code_hit) live <= arm;
			else if (fresh) live <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/field_capture.sv */
// big-endian collector of a fixed-length header body into a payload type
`default_nettype none

module field_capture #(
	parameter type payload_t = logic [63:0],
	parameter int n_bytes = 8
) (
	input logic clk,
	input logic rst_n,
	input logic arm,
	input logic en,
	input logic [7:0] data,
	output logic busy,
	output logic done,
	output payload_t payload
);

	localparam int pw = $bits(payload_t);
	localparam int cw = $clog2(n_bytes + 1);

	// bytes taken so far in this capture
	logic [cw-1:0] cnt;
	// shift register, first byte ends up at the top
	logic [pw-1:0] shreg;
	// the current byte is the last of the body
	logic last_byte;

	// arm wins over an ongoing capture
	assign last_byte = busy && !arm && (cnt == cw'(n_bytes - 1));

	// capture control
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (en) begin
			if (arm) begin
				// the arm byte itself is the code, not body
				busy <= 1'b1;
				cnt <= '0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (last_byte) busy <= 1'b0;
			end
		end
	end

	// done is high for a single clock after the last byte
	always_ff @(posedge clk) begin
		if (!rst_n) done <= 1'b0;
		else done <= en && last_byte;
	end

	// body bytes enter at the bottom, msb first on the wire
	always_ff @(posedge clk) begin
		if (en && busy && !arm) shreg <= {shreg[pw-9:0], data};
	end

	// stays put after done until the next capture starts
	assign payload = payload_t'(shreg);

endmodule

`default_nettype wire

/* hw/start_code_detect.sv */
// start code detector, marks the code byte that follows each 00 00 01 prefix
`default_nettype none

module start_code_detect (
	input logic clk,
	input logic rst_n,
	input logic [7:0] in_data,
	input logic in_en,
	byte_stream_if.src bs
);

	// last and second to last accepted bytes
	logic [7:0] hist_1;
	logic [7:0] hist_2;
	// prefix finished on the previous accepted byte
	logic prefix_done;
	// the current byte closes a prefix
	logic prefix_now;

	// ************************************************************
	// byte history
	// ************************************************************

	assign prefix_now = (hist_2 == 8'h00) && (hist_1 == 8'h00) && (in_data == 8'h01);

	// history only moves on accepted bytes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// non-zero so reset does not look like a zero run
			hist_1 <= 8'hff;
			hist_2 <= 8'hff;
			prefix_done <= 1'b0;
		end else if (in_en) begin
			hist_2 <= hist_1;
			hist_1 <= in_data;
			// a run of three or more zeros before 01 still counts
			prefix_done <= prefix_now;
		end
	end

	// ************************************************************
	// byte stream out
	// ************************************************************

	// data and strobe pass on untouched
	assign bs.data = in_data;
	assign bs.en = in_en;

	// code byte is the first accepted byte after the prefix
	assign bs.code_hit = in_en && prefix_done;
	assign bs.code = in_data;

	// a code byte is never directly followed by another one
	// since a new prefix needs at least three more bytes
	code_hit_spacing: assert property (
		@(posedge clk) disable iff (!rst_n)
		bs.code_hit |-> bs.en ##1 !bs.code_hit
	);

endmodule

`default_nettype wire

/* hw/mpeg_sys_ifs.sv */
// byte stream and stream table interfaces between the demux blocks
`default_nettype none

// ************************************************************
// stream bytes with the start code marker
// ************************************************************

interface byte_stream_if;
	// raw byte and its strobe, straight from the top inputs
	logic [7:0] data;
	logic en;
	// high on the code byte after 00 00 01
	logic code_hit;
	logic [7:0] code;

	modport src (output data, output en, output code_hit, output code);
	modport dst (input data, input en, input code_hit, input code);
endinterface

// ************************************************************
// stream table write side
// ************************************************************

interface stream_entry_if import mpeg_sys_pkg::*; ();
	// one-cycle pulses from the system header parser
	logic clear;
	logic wr;
	stream_entry_t entry;
	// occupied slots, from the table
	logic [3:0] count;

	modport wr_port (output clear, output wr, output entry, input count);
	modport table_port (input clear, input wr, input entry, output count);
endinterface

`default_nettype wire

/* hw/mpeg_sys_pkg.sv */
// start code values and header layouts for the MPEG-1 system stream front end
`default_nettype none

package mpeg_sys_pkg;

	// code bytes that follow the 00 00 01 prefix
	localparam logic [7:0] CODE_PACK = 8'hBA;
	localparam logic [7:0] CODE_SYSTEM = 8'hBB;

	// pack header body, byte 0 is the first on the wire
	typedef logic [0:7][7:0] pack_hdr_t;

	// fixed part of the system header in wire order
	typedef struct packed {
		// bytes that follow the length field
		logic [15:0] length;
		// marker, rate_bound[21:0], marker
		logic [23:0] rate_field;
		// audio_bound[5:0], fixed_flag, csps_flag
		logic [7:0] audio_byte;
		// audio_lock, video_lock, marker, video_bound[4:0]
		logic [7:0] video_byte;
		logic [7:0] reserved;
	} sys_fixed_t;

	// one stream entry as kept in the table
	typedef struct packed {
		logic [7:0] stream_id;
		logic bufsize_scale;
		logic [12:0] bufsize;
	} stream_entry_t;

	// system header flags
	typedef struct packed {
		logic fixed_flag;
		logic csps_flag;
		logic audio_lock;
		logic video_lock;
	} sys_flags_t;

endpackage

`default_nettype wire

/* hw/mpeg_sys_defs.svh */
// sizing constants for the MPEG-1 system stream front end

`ifndef MPEG_SYS_DEFS_SVH
`define MPEG_SYS_DEFS_SVH

// ************************************************************
// stream table
// ************************************************************

// entries in the stream id table, a power of two
`define STREAM_SLOTS 8

// ************************************************************
// header byte counts, start code not included
// ************************************************************

// pack header body after the BA code byte
`define PACK_BODY_BYTES 8
// length field plus the six fixed bytes of the system header
`define SYS_FIXED_BYTES 8
// one stream entry: id, then scale and size in two bytes
`define ENTRY_BYTES 3

`endif
